/* design/mc_io_pkg.sv */
`default_nettype none

package mc_io_pkg;

  localparam int DATA_W       = 32;
  localparam int ADDR_W       = 8;
  localparam int NUM_TILES    = 16;
  localparam int TILE_ID_W    = $clog2(NUM_TILES);
  localparam int COUNT_W      = 16;
  localparam int FINISH_CNT_W = $clog2(NUM_TILES) + 1; // must hold 0..16
  localparam int RESET_DEPTH  = 3;
  localparam int TAG_CNT_W    = 4;                      // wide enough for both phases

  typedef logic [DATA_W-1:0]    data_t;
  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [TILE_ID_W-1:0] tile_id_t;
  typedef logic [NUM_TILES-1:0] tile_mask_t;
  typedef logic [COUNT_W-1:0]   count_t;

  // host address map, word addresses
  localparam addr_t ADDR_FINISH     = 8'h00;
  localparam addr_t ADDR_PRINT_STAT = 8'h04;
  localparam addr_t ADDR_STATUS     = 8'h08;
  localparam addr_t ADDR_CYCLE      = 8'h0C;

  // status word layout
  localparam int STATUS_ALL_FIN_BIT = 31;
  localparam int STATUS_FIN_LSB     = 16;
  localparam int STATUS_STAT_LSB    = 0;

  typedef enum logic [1:0] {
    IDLE,
    SHIFT,
    HOLD,
    RUN
  } tag_state_e;

endpackage

`default_nettype wire

/* design/mc_tag_programmer.sv */
`timescale 1ns/100ps
`default_nettype none

module mc_tag_programmer (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  mc_io_pkg::tile_mask_t tile_enable_i,
  output logic                  tag_en_o,
  output logic                  tag_data_o,
  output logic                  tag_done_o,
  output logic                  core_reset_o
);

  import mc_io_pkg::*;

  tag_state_e           state_r;
  logic [TAG_CNT_W-1:0] cnt_r;
  tile_mask_t           shift_r;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_r <= IDLE;
      cnt_r   <= '0;
    end else begin
      case (state_r)
        IDLE: begin
          state_r <= SHIFT;
          cnt_r   <= '0;
        end
        SHIFT: begin
          if (cnt_r == TAG_CNT_W'(NUM_TILES - 1)) begin
            state_r <= HOLD;
            cnt_r   <= '0; // reused for the reset delay
          end else begin
            cnt_r <= cnt_r + 1'b1;
          end
        end
        HOLD: begin
          if (cnt_r == TAG_CNT_W'(RESET_DEPTH - 1)) begin
            state_r <= RUN;
          end else begin
            cnt_r <= cnt_r + 1'b1;
          end
        end
        default: state_r <= RUN;
      endcase
    end
  end

  // lsb goes out first
  always_ff @(posedge clk_i) begin
    if (state_r == IDLE) begin
      shift_r <= tile_enable_i;
    end else if (state_r == SHIFT) begin
      shift_r <= shift_r >> 1;
    end
  end

  assign tag_en_o     = (state_r == SHIFT);
  assign tag_data_o   = shift_r[0];
  assign tag_done_o   = (state_r == HOLD) || (state_r == RUN);
  assign core_reset_o = (state_r != RUN);

endmodule

`default_nettype wire

/* design/mc_print_stat_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module mc_print_stat_decoder (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              core_reset_i,
  input  logic              wr_accept_i,
  input  mc_io_pkg::addr_t  adr_i,
  input  mc_io_pkg::data_t  dat_i,
  output logic              print_stat_v_o,
  output mc_io_pkg::data_t  print_stat_tag_o,
  output mc_io_pkg::count_t stat_count_o
);

  import mc_io_pkg::*;

  logic   hit;
  logic   stat_v_r;
  data_t  tag_r;
  count_t stat_cnt_r;

  // ignored while the cores are held in reset
  assign hit = wr_accept_i && (adr_i == ADDR_PRINT_STAT) && !core_reset_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      stat_v_r   <= 1'b0;
      stat_cnt_r <= '0;
    end else if (core_reset_i) begin
      stat_v_r   <= 1'b0;
      stat_cnt_r <= '0;
    end else begin
      stat_v_r <= hit;
      if (hit) begin
        stat_cnt_r <= stat_cnt_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (hit) begin
      tag_r <= dat_i;
    end
  end

  assign print_stat_v_o   = stat_v_r;
  assign print_stat_tag_o = tag_r;
  assign stat_count_o     = stat_cnt_r;

endmodule

`default_nettype wire

/* design/mc_finish_tracker.sv */
`timescale 1ns/100ps
`default_nettype none

module mc_finish_tracker (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                core_reset_i,
  input  mc_io_pkg::tile_mask_t               tile_enable_i,
  input  logic                                wr_accept_i,
  input  mc_io_pkg::addr_t                    adr_i,
  input  mc_io_pkg::data_t                    dat_i,
  output logic                                all_finished_o,
  output logic [mc_io_pkg::FINISH_CNT_W-1:0]  finish_count_o
);

  import mc_io_pkg::*;

  tile_id_t                tile_id;
  tile_mask_t              mask_r;
  tile_mask_t              mask_nxt;
  logic                    all_fin_r;
  logic [FINISH_CNT_W-1:0] pop;

  assign tile_id = dat_i[TILE_ID_W-1:0];

  always_comb begin
    mask_nxt = mask_r;
    if (wr_accept_i && (adr_i == ADDR_FINISH) && tile_enable_i[tile_id]) begin
      mask_nxt[tile_id] = 1'b1; // repeats are harmless
    end
  end

  // flag looks at the next mask so it lands one cycle after the ack
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mask_r    <= '0;
      all_fin_r <= 1'b0;
    end else if (core_reset_i) begin
      mask_r    <= '0;
      all_fin_r <= 1'b0;
    end else begin
      mask_r    <= mask_nxt;
      all_fin_r <= (mask_nxt == tile_enable_i) && (|tile_enable_i);
    end
  end

  always_comb begin
    pop = '0;
    for (int i = 0; i < NUM_TILES; i++) begin
      pop = pop + FINISH_CNT_W'(mask_r[i]);
    end
  end

  assign all_finished_o = all_fin_r;
  assign finish_count_o = pop;

endmodule

`default_nettype wire

/* design/mc_host_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module mc_host_regs (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                core_reset_i,
  input  logic                                wb_cyc_i,
  input  logic                                wb_stb_i,
  input  logic                                wb_we_i,
  input  mc_io_pkg::addr_t                    wb_adr_i,
  output logic                                wb_ack_o,
  output mc_io_pkg::data_t                    wb_dat_o,
  output logic                                wr_accept_o,
  input  mc_io_pkg::count_t                   stat_count_i,
  input  logic [mc_io_pkg::FINISH_CNT_W-1:0]  finish_count_i,
  input  logic                                all_finished_i
);

  import mc_io_pkg::*;

  logic   ack_r;
  count_t cycle_r;
  data_t  status;

  // one ack per request, never back to back
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_r <= 1'b0;
    end else begin
      ack_r <= wb_cyc_i && wb_stb_i && !ack_r;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cycle_r <= '0;
    end else if (core_reset_i) begin
      cycle_r <= '0;
    end else if (cycle_r != '1) begin
      cycle_r <= cycle_r + 1'b1; // saturating
    end
  end

  always_comb begin
    status = '0;
    status[STATUS_ALL_FIN_BIT] = all_finished_i;
    status[STATUS_FIN_LSB +: FINISH_CNT_W] = finish_count_i;
    status[STATUS_STAT_LSB +: COUNT_W] = stat_count_i;
  end

  always_comb begin
    case (wb_adr_i)
      ADDR_STATUS: wb_dat_o = status;
      ADDR_CYCLE:  wb_dat_o = DATA_W'(cycle_r);
      default:     wb_dat_o = '0;
    endcase
  end

  assign wb_ack_o    = ack_r;
  assign wr_accept_o = ack_r && wb_we_i; // decoders match their own addresses

endmodule

`default_nettype wire

/* design/mc_io_complex.sv */
`timescale 1ns/100ps
`default_nettype none

module mc_io_complex (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  mc_io_pkg::tile_mask_t tile_enable_i,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  mc_io_pkg::addr_t      wb_adr_i,
  input  mc_io_pkg::data_t      wb_dat_i,
  output mc_io_pkg::data_t      wb_dat_o,
  output logic                  wb_ack_o,
  output logic                  tag_en_o,
  output logic                  tag_data_o,
  output logic                  tag_done_o,
  output logic                  core_reset_o,
  output logic                  print_stat_v_o,
  output mc_io_pkg::data_t      print_stat_tag_o,
  output logic                  all_finished_o
);

  import mc_io_pkg::*;

  logic                    wr_accept;
  count_t                  stat_count;
  logic [FINISH_CNT_W-1:0] finish_count;

  mc_tag_programmer tag_prog_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .tile_enable_i (tile_enable_i),
    .tag_en_o      (tag_en_o),
    .tag_data_o    (tag_data_o),
    .tag_done_o    (tag_done_o),
    .core_reset_o  (core_reset_o)
  );

  mc_print_stat_decoder print_stat_i (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .core_reset_i     (core_reset_o),
    .wr_accept_i      (wr_accept),
    .adr_i            (wb_adr_i),
    .dat_i            (wb_dat_i),
    .print_stat_v_o   (print_stat_v_o),
    .print_stat_tag_o (print_stat_tag_o),
    .stat_count_o     (stat_count)
  );

  mc_finish_tracker finish_i (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .core_reset_i   (core_reset_o),
    .tile_enable_i  (tile_enable_i),
    .wr_accept_i    (wr_accept),
    .adr_i          (wb_adr_i),
    .dat_i          (wb_dat_i),
    .all_finished_o (all_finished_o),
    .finish_count_o (finish_count)
  );

  mc_host_regs host_regs_i (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .core_reset_i   (core_reset_o),
    .wb_cyc_i       (wb_cyc_i),
    .wb_stb_i       (wb_stb_i),
    .wb_we_i        (wb_we_i),
    .wb_adr_i       (wb_adr_i),
    .wb_ack_o       (wb_ack_o),
    .wb_dat_o       (wb_dat_o),
    .wr_accept_o    (wr_accept),
    .stat_count_i   (stat_count),
    .finish_count_i (finish_count),
    .all_finished_i (all_finished_o)
  );

endmodule

`default_nettype wire

/* sim/mc_io_complex_assert.sv */
`timescale 1ns/100ps
`default_nettype none

module mc_io_complex_assert (
  input logic clk_i,
  input logic rst_n_i,
  input logic cyc_i,
  input logic stb_i,
  input logic ack_i,
  input logic tag_done_i,
  input logic core_reset_i
);

  import mc_io_pkg::*;

  ack_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ack_i |=> !ack_i)
    else $error("wb ack held for more than one cycle");

  // ack only answers a request seen the cycle before
  ack_after_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ack_i |-> $past(cyc_i && stb_i))
    else $error("wb ack without cyc and stb");

  core_release_delay: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(core_reset_i) |-> $past(tag_done_i, RESET_DEPTH) && !$past(tag_done_i, RESET_DEPTH + 1))
    else $error("core reset released at the wrong distance from tag done");

endmodule

bind mc_host_regs mc_io_complex_assert wb_assert_i (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .cyc_i        (wb_cyc_i),
  .stb_i        (wb_stb_i),
  .ack_i        (wb_ack_o),
  .tag_done_i   (1'b0),
  .core_reset_i (1'b1) // reset timing is watched on the tag side
);

bind mc_tag_programmer mc_io_complex_assert tag_assert_i (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .cyc_i        (1'b0),
  .stb_i        (1'b0),
  .ack_i        (1'b0),
  .tag_done_i   (tag_done_o),
  .core_reset_i (core_reset_o)
);

`default_nettype wire

/* sim/mc_io_complex_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module mc_io_complex_tb;

  import mc_io_pkg::*;

  localparam int          MAX_TXNS        = 300;
  localparam int          WATCHDOG_CYCLES = 100 + MAX_TXNS * 13; // 13 cycles per transaction at most
  localparam logic [15:0] SEED            = 16'd15271;

  logic       clk_i;
  logic       rst_n_i;
  tile_mask_t tile_enable_i;
  logic       wb_cyc_i;
  logic       wb_stb_i;
  logic       wb_we_i;
  addr_t      wb_adr_i;
  data_t      wb_dat_i;
  data_t      wb_dat_o;
  logic       wb_ack_o;
  logic       tag_en_o;
  logic       tag_data_o;
  logic       tag_done_o;
  logic       core_reset_o;
  logic       print_stat_v_o;
  data_t      print_stat_tag_o;
  logic       all_finished_o;

  logic [15:0] lfsr_q;
  int          err_cnt;
  int          chk_cnt;
  int          pulse_cnt = 0;
  tile_mask_t  exp_mask;     // model of the finish mask
  count_t      exp_stat_cnt;
  data_t       exp_tag;
  data_t       last_cycle;

  mc_io_complex mc_io_complex_i (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .tile_enable_i    (tile_enable_i),
    .wb_cyc_i         (wb_cyc_i),
    .wb_stb_i         (wb_stb_i),
    .wb_we_i          (wb_we_i),
    .wb_adr_i         (wb_adr_i),
    .wb_dat_i         (wb_dat_i),
    .wb_dat_o         (wb_dat_o),
    .wb_ack_o         (wb_ack_o),
    .tag_en_o         (tag_en_o),
    .tag_data_o       (tag_data_o),
    .tag_done_o       (tag_done_o),
    .core_reset_o     (core_reset_o),
    .print_stat_v_o   (print_stat_v_o),
    .print_stat_tag_o (print_stat_tag_o),
    .all_finished_o   (all_finished_o)
  );

  always #50 clk_i = ~clk_i;

  always @(negedge clk_i) begin
    if (print_stat_v_o) pulse_cnt++; // counts stray strobes too
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic data_t rand_bits(input int n);
    data_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[DATA_W-2:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic addr_t rand_unmapped();
    addr_t a;
    a = addr_t'(rand_bits(ADDR_W));
    while (a == ADDR_FINISH || a == ADDR_PRINT_STAT || a == ADDR_STATUS || a == ADDR_CYCLE) begin
      a = addr_t'(rand_bits(ADDR_W));
    end
    return a;
  endfunction

  function automatic logic model_all_fin();
    return (exp_mask == tile_enable_i) && (tile_enable_i != '0);
  endfunction

  task automatic check_value(input string what, input data_t got, input data_t exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // returns in the cycle after the ack
  task automatic wb_write(input addr_t adr, input data_t dat);
    @(negedge clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b1;
    wb_adr_i = adr;
    wb_dat_i = dat;
    @(negedge clk_i);
    while (!wb_ack_o) begin
      @(negedge clk_i);
    end
    @(negedge clk_i); // held through the ack edge
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_read(input addr_t adr, output data_t dat);
    @(negedge clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b0;
    wb_adr_i = adr;
    @(negedge clk_i);
    while (!wb_ack_o) begin
      @(negedge clk_i);
    end
    dat = wb_dat_o; // valid in the ack cycle
    @(negedge clk_i);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
  endtask

  task automatic check_status();
    data_t rd;
    data_t exp;
    exp = '0;
    exp[31]    = model_all_fin();
    exp[20:16] = 5'($countones(exp_mask));
    exp[15:0]  = exp_stat_cnt;
    wb_read(ADDR_STATUS, rd);
    check_value("status word", rd, exp);
  endtask

  task automatic finish_write(input data_t dat);
    wb_write(ADDR_FINISH, dat);
    if (tile_enable_i[dat[3:0]]) exp_mask[dat[3:0]] = 1'b1;
    check_value("all_finished_o", 32'(all_finished_o), 32'(model_all_fin()));
  endtask

  task automatic print_stat_write(input data_t tag);
    wb_write(ADDR_PRINT_STAT, tag);
    exp_stat_cnt++;
    exp_tag = tag;
    check_value("print_stat_v_o", 32'(print_stat_v_o), 32'd1);
    check_value("print_stat_tag_o", print_stat_tag_o, exp_tag);
  endtask

  initial begin
    data_t rd;
    data_t rd2;
    data_t tag_bits;
    int    gap;
    int    hold_cnt;
    addr_t adr;

    lfsr_q        = SEED;
    err_cnt       = 0;
    chk_cnt       = 0;
    clk_i         = 1'b0;
    rst_n_i       = 1'b0;
    wb_cyc_i      = 1'b0;
    wb_stb_i      = 1'b0;
    wb_we_i       = 1'b0;
    wb_adr_i      = '0;
    wb_dat_i      = '0;
    exp_mask      = '0;
    exp_stat_cnt  = '0;
    exp_tag       = '0;
    last_cycle    = '0;
    tile_enable_i = tile_mask_t'(rand_bits(NUM_TILES));

    repeat (16) @(negedge clk_i);
    check_value("core_reset_o in reset", 32'(core_reset_o), 32'd1);
    check_value("tag_en_o in reset", 32'(tag_en_o), 32'd0);
    check_value("tag_done_o in reset", 32'(tag_done_o), 32'd0);
    check_value("wb_ack_o in reset", 32'(wb_ack_o), 32'd0);
    check_value("print_stat_v_o in reset", 32'(print_stat_v_o), 32'd0);
    rst_n_i = 1'b1;

    // serial tag stream comes lsb first
    while (!tag_en_o) begin
      @(negedge clk_i);
    end
    tag_bits = '0;
    for (int i = 0; i < NUM_TILES; i++) begin
      check_value("tag_en_o while shifting", 32'(tag_en_o), 32'd1);
      tag_bits[i] = tag_data_o;
      @(negedge clk_i);
    end
    check_value("tag stream", tag_bits, 32'(tile_enable_i));
    check_value("tag_en_o after shift", 32'(tag_en_o), 32'd0);
    check_value("tag_done_o after shift", 32'(tag_done_o), 32'd1);
    hold_cnt = 0;
    while (core_reset_o) begin
      hold_cnt++;
      @(negedge clk_i);
    end
    check_value("core reset hold cycles", 32'(hold_cnt), 32'(RESET_DEPTH));

    for (int i = 0; i < 24; i++) begin
      gap = int'(rand_bits(2));
      repeat (gap) @(negedge clk_i);
      print_stat_write(rand_bits(DATA_W));
    end

    // random finishes including repeats and disabled tiles
    for (int i = 0; i < 40; i++) begin
      finish_write(rand_bits(DATA_W));
      check_status();
    end
    for (int i = 0; i < NUM_TILES; i++) begin
      if (tile_enable_i[i]) begin
        rd = rand_bits(28);
        rd = {rd[27:0], 4'(i)};
        finish_write(rd);
      end
    end
    check_status();

    for (int i = 0; i < 16; i++) begin
      adr = rand_unmapped();
      wb_read(adr, rd);
      check_value("unmapped read", rd, '0);
      wb_write(adr, rand_bits(DATA_W));
      check_status();
    end

    for (int i = 0; i < 8; i++) begin
      wb_read(ADDR_CYCLE, rd);
      check_value("cycle counter monotonic", 32'(rd >= last_cycle), 32'd1);
      gap = int'(rand_bits(4));
      repeat (gap) @(negedge clk_i);
      wb_read(ADDR_CYCLE, rd2);
      check_value("cycle counter step", 32'((rd2 - rd) >= data_t'(gap)), 32'd1);
      last_cycle = rd2;
    end

    @(negedge clk_i);
    check_value("print_stat pulse count", pulse_cnt, 32'(exp_stat_cnt));

    $display("%0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, the DUT stopped responding", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
design/mc_io_pkg.sv
design/mc_tag_programmer.sv
design/mc_print_stat_decoder.sv
design/mc_finish_tracker.sv
design/mc_host_regs.sv
design/mc_io_complex.sv
sim/mc_io_complex_assert.sv
sim/mc_io_complex_tb.sv

/* Makefile */
TOP := mc_io_complex_tb

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

obj_dir/V$(TOP): list.f $(shell cat list.f)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f list.f

clean:
	rm -rf obj_dir
